/* flist.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/uop_pkg.sv
hdl/decode_ifs.sv
hdl/funct_decode.sv
hdl/imm_gen.sv
hdl/uop_assemble.sv
hdl/decode_top.sv
tb/decode_asserts.sv
tb/decode_checker.sv
tb/tb_decode_top.sv

/* hdl/decode_consts.svh */
// RV32 only; the immediate paths assume XLEN is 32 and the CSR stall covers addresses up to fcsr
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Data path width
`define XLEN 32

// Register index width
`define REG_ADDR_W 5

// Micro-op code width
`define OP_W 4

// Highest floating-point CSR address
`define FCSR_ADDR 12'h003

// Immediate of ECALL and the returns
`define RET_IMM 4

`endif

/* hdl/decode_ifs.sv */
// Internal decode buses; all signals are combinational and carry no handshake
`timescale 1ns/100ps

// Function-field decode results
interface funct_if import uop_pkg::*; ();

    alu_op_e alu_op;
    br_op_e  br_op;
    br_op_e  sys_op;   // ECALL, EBREAK and returns
    csr_op_e csr_op;

    modport drv  (output alu_op, br_op, sys_op, csr_op);
    modport user (input  alu_op, br_op, sys_op, csr_op);

endinterface

// Sign-extended immediates of every format
interface imm_if import isa_pkg::*; ();

    xlen_t i_imm;
    xlen_t s_imm;
    xlen_t b_imm;
    xlen_t u_imm;
    xlen_t j_imm;

    modport drv  (output i_imm, s_imm, b_imm, u_imm, j_imm);
    modport user (input  i_imm, s_imm, b_imm, u_imm, j_imm);

endinterface

/* hdl/decode_top.sv */
// Decode stage top; one instruction per cycle in, one micro-op out a cycle later
`timescale 1ns/100ps

module decode_top import isa_pkg::*, uop_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  instr_t     in_instr,
    input  xlen_t      in_pc,
    input  wid_t       in_wid,
    output logic       out_valid,
    input  logic       out_ready,
    output xlen_t      out_pc,
    output wid_t       out_wid,
    output ex_type_e   out_ex_type,
    output op_code_t   out_op,
    output alu_xtype_e out_xtype,
    output logic       out_use_imm,
    output logic       out_use_pc,
    output xlen_t      out_imm,
    output logic       out_wb,
    output reg_addr_t  out_rd,
    output reg_addr_t  out_rs1,
    output reg_addr_t  out_rs2,
    output logic [1:0] out_used_rs,
    output logic       sched_valid,
    output logic       sched_unlock,
    output wid_t       sched_wid
);

    funct_if fn_bus ();
    imm_if   imm_bus ();

    funct_decode funct_decode_inst (
        .instr (in_instr),
        .fn    (fn_bus)
    );

    imm_gen imm_gen_inst (
        .instr (in_instr),
        .imm   (imm_bus)
    );

    uop_assemble uop_assemble_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (in_instr),
        .pc           (in_pc),
        .wid          (in_wid),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .fn           (fn_bus),
        .imm          (imm_bus),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_pc       (out_pc),
        .out_wid      (out_wid),
        .out_ex_type  (out_ex_type),
        .out_op       (out_op),
        .out_xtype    (out_xtype),
        .out_use_imm  (out_use_imm),
        .out_use_pc   (out_use_pc),
        .out_imm      (out_imm),
        .out_wb       (out_wb),
        .out_rd       (out_rd),
        .out_rs1      (out_rs1),
        .out_rs2      (out_rs2),
        .out_used_rs  (out_used_rs),
        .sched_valid  (sched_valid),
        .sched_unlock (sched_unlock),
        .sched_wid    (sched_wid)
    );

endmodule

/* hdl/funct_decode.sv */
// Opcode-blind decode; results are only meaningful for the opcode that the assembler selects
`timescale 1ns/100ps

module funct_decode import isa_pkg::*, uop_pkg::*; (
    input instr_t instr,
    funct_if.drv  fn
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    csr_addr_t  sys_field;

    assign funct3    = instr[14:12];
    assign funct7    = instr[31:25];
    assign sys_field = instr[31:20];

    always_comb begin
        case (funct3)
            3'h0: fn.alu_op = (instr[5] && funct7[5]) ? ALU_SUB : ALU_ADD; // No SUBI
            3'h1: fn.alu_op = ALU_SLL;
            3'h2: fn.alu_op = ALU_SLT;
            3'h3: fn.alu_op = ALU_SLTU;
            3'h4: fn.alu_op = ALU_XOR;
            3'h5: fn.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'h6: fn.alu_op = ALU_OR;
            default: fn.alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'h0: fn.br_op = BR_BEQ;
            3'h1: fn.br_op = BR_BNE;
            3'h4: fn.br_op = BR_BLT;
            3'h5: fn.br_op = BR_BGE;
            3'h6: fn.br_op = BR_BLTU;
            3'h7: fn.br_op = BR_BGEU;
            default: fn.br_op = BR_NONE; // Reserved
        endcase
    end

    always_comb begin
        case (sys_field)
            12'h000: fn.sys_op = BR_ECALL;
            12'h001: fn.sys_op = BR_EBREAK;
            12'h002: fn.sys_op = BR_URET;
            12'h102: fn.sys_op = BR_SRET;
            12'h302: fn.sys_op = BR_MRET;
            default: fn.sys_op = BR_NONE;
        endcase
    end

    assign fn.csr_op = csr_op_e'(funct3[1:0]);

endmodule

/* hdl/imm_gen.sv */
// RV32 formats only; shift masking of the I immediate applies to OP-IMM, loads and JALR keep the full field
`timescale 1ns/100ps
`include "decode_consts.svh"

module imm_gen import isa_pkg::*; (
    input instr_t instr,
    imm_if.drv    imm
);

    logic is_shift_imm;
    xlen_t i_full;

    // SLLI, SRLI, SRAI
    assign is_shift_imm = (instr[6:0] == OPC_OP_IMM) && (instr[13:12] == 2'b01);

    assign i_full = {{(`XLEN-12){instr[31]}}, instr[31:20]};

    assign imm.i_imm = is_shift_imm ? {{(`XLEN-5){1'b0}}, instr[24:20]} : i_full;
    assign imm.s_imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm.b_imm = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                        instr[11:8], 1'b0};
    assign imm.u_imm = {instr[31:12], 12'b0};
    assign imm.j_imm = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                        instr[30:21], 1'b0};

endmodule

/* hdl/isa_pkg.sv */
// Base RV32I encodings only; opcodes of the M, F, D and GPU extensions are not listed
`include "decode_consts.svh"

package isa_pkg;

    typedef logic [31:0]            instr_t;
    typedef logic [`XLEN-1:0]       xlen_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [1:0]             wid_t;     // Four warps
    typedef logic [11:0]            csr_addr_t;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'h03,
        OPC_FENCE  = 7'h0F,
        OPC_OP_IMM = 7'h13,
        OPC_AUIPC  = 7'h17,
        OPC_STORE  = 7'h23,
        OPC_OP     = 7'h33,
        OPC_LUI    = 7'h37,
        OPC_BRANCH = 7'h63,
        OPC_JALR   = 7'h67,
        OPC_JAL    = 7'h6F,
        OPC_SYSTEM = 7'h73
    } opcode_e;

endpackage

/* hdl/uop_assemble.sv */
// One-entry output stage with one cycle of latency; a CSR register form carries its address in imm
`timescale 1ns/100ps
`include "decode_consts.svh"

module uop_assemble import isa_pkg::*, uop_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  instr_t     instr,
    input  xlen_t      pc,
    input  wid_t       wid,
    input  logic       in_valid,
    output logic       in_ready,
    funct_if.user      fn,
    imm_if.user        imm,
    output logic       out_valid,
    input  logic       out_ready,
    output xlen_t      out_pc,
    output wid_t       out_wid,
    output ex_type_e   out_ex_type,
    output op_code_t   out_op,
    output alu_xtype_e out_xtype,
    output logic       out_use_imm,
    output logic       out_use_pc,
    output xlen_t      out_imm,
    output logic       out_wb,
    output reg_addr_t  out_rd,
    output reg_addr_t  out_rs1,
    output reg_addr_t  out_rs2,
    output logic [1:0] out_used_rs,
    output logic       sched_valid,
    output logic       sched_unlock,
    output wid_t       sched_wid
);

    opcode_e    opcode;
    logic [2:0] funct3;
    reg_addr_t  rd, rs1, rs2;
    csr_addr_t  csr_addr;

    ex_type_e   ex_type;
    op_code_t   op_sel;
    alu_xtype_e xtype;
    logic       use_imm, use_pc;
    xlen_t      imm_sel;
    logic       use_rd, use_rs1, use_rs2;
    logic       stall;
    logic       fire_in;

    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign rd       = instr[11:7];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign csr_addr = instr[31:20];

    always_comb begin
        ex_type = EX_NONE;
        op_sel  = '0;
        xtype   = ALU_ARITH;
        use_imm = 1'b0;
        use_pc  = 1'b0;
        imm_sel = '0;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        stall   = 1'b0;
        case (opcode)
            OPC_OP_IMM, OPC_OP: begin
                ex_type = EX_ALU;
                op_sel  = op_code_t'(fn.alu_op);
                use_imm = (opcode == OPC_OP_IMM);
                imm_sel = (opcode == OPC_OP_IMM) ? imm.i_imm : '0;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = (opcode == OPC_OP);
            end
            OPC_LUI, OPC_AUIPC: begin
                ex_type = EX_ALU;
                op_sel  = (opcode == OPC_LUI) ? op_code_t'(ALU_LUI) : op_code_t'(ALU_AUIPC);
                use_imm = 1'b1;
                use_pc  = (opcode == OPC_AUIPC);
                imm_sel = imm.u_imm;
                use_rd  = 1'b1;
            end
            OPC_JAL: begin
                ex_type = EX_ALU;
                op_sel  = op_code_t'(BR_JAL);
                xtype   = ALU_BRANCH;
                use_imm = 1'b1;
                use_pc  = 1'b1;
                imm_sel = imm.j_imm;
                use_rd  = 1'b1;
                stall   = 1'b1;
            end
            OPC_JALR: begin
                ex_type = EX_ALU;
                op_sel  = op_code_t'(BR_JALR);
                xtype   = ALU_BRANCH;
                use_imm = 1'b1;
                imm_sel = imm.i_imm; // Target is rs1 + imm
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                stall   = 1'b1;
            end
            OPC_BRANCH: begin
                ex_type = EX_ALU;
                op_sel  = op_code_t'(fn.br_op);
                xtype   = ALU_BRANCH;
                use_imm = 1'b1;
                use_pc  = 1'b1;
                imm_sel = imm.b_imm;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                stall   = 1'b1;
            end
            OPC_FENCE: begin
                ex_type = EX_LSU; // Op code 0, no offset
            end
            OPC_LOAD: begin
                ex_type = EX_LSU;
                op_sel  = {1'b0, funct3};
                use_imm = 1'b1;
                imm_sel = imm.i_imm;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
            end
            OPC_STORE: begin
                ex_type = EX_LSU;
                op_sel  = {1'b1, funct3};
                use_imm = 1'b1;
                imm_sel = imm.s_imm;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPC_SYSTEM: begin
                use_rd = 1'b1;
                if (funct3[1:0] != 2'b00) begin
                    ex_type = EX_SFU;
                    op_sel  = op_code_t'(fn.csr_op);
                    use_imm = funct3[2];
                    stall   = (csr_addr <= `FCSR_ADDR); // FPU CSRs only
                    if (funct3[2]) begin
                        imm_sel = {{(`XLEN-`REG_ADDR_W){1'b0}}, rs1}; // uimm in rs1 field
                    end else begin
                        imm_sel = {{(`XLEN-12){1'b0}}, csr_addr};
                        use_rs1 = 1'b1;
                    end
                end else begin
                    ex_type = EX_ALU;
                    op_sel  = op_code_t'(fn.sys_op);
                    xtype   = ALU_BRANCH;
                    use_imm = 1'b1;
                    use_pc  = 1'b1;
                    imm_sel = (fn.sys_op == BR_EBREAK) ? '0 : xlen_t'(`RET_IMM);
                    stall   = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // Output register frees up in the cycle it drains
    assign in_ready = ~out_valid | out_ready;
    assign fire_in  = in_valid & in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fire_in) begin
            out_pc      <= pc;
            out_wid     <= wid;
            out_ex_type <= ex_type;
            out_op      <= op_sel;
            out_xtype   <= xtype;
            out_use_imm <= use_imm;
            out_use_pc  <= use_pc;
            out_imm     <= imm_sel;
            out_wb      <= use_rd && (rd != '0); // x0 never written
            out_rd      <= rd;
            out_rs1     <= rs1;
            out_rs2     <= rs2;
            out_used_rs <= {use_rs2, use_rs1};
        end
    end

    // Scheduler notice in the accept cycle
    assign sched_valid  = fire_in;
    assign sched_wid    = wid;
    assign sched_unlock = ~stall;

endmodule

/* hdl/uop_pkg.sv */
// Micro-op encodings of the decode stage; ALU, branch and CSR codes share the 4-bit op field
`include "decode_consts.svh"

package uop_pkg;

    typedef enum logic [1:0] {
        EX_NONE,
        EX_ALU,
        EX_LSU,
        EX_SFU
    } ex_type_e;

    typedef enum logic [1:0] {
        ALU_ARITH,
        ALU_BRANCH
    } alu_xtype_e;

    typedef logic [`OP_W-1:0] op_code_t;

    typedef enum logic [`OP_W-1:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_LUI   = 4'd10,
        ALU_AUIPC = 4'd11
    } alu_op_e;

    // Branches, jumps and system returns
    typedef enum logic [`OP_W-1:0] {
        BR_BEQ    = 4'd0,
        BR_BNE    = 4'd1,
        BR_BLT    = 4'd2,
        BR_BGE    = 4'd3,
        BR_BLTU   = 4'd4,
        BR_BGEU   = 4'd5,
        BR_JAL    = 4'd6,
        BR_JALR   = 4'd7,
        BR_ECALL  = 4'd8,
        BR_EBREAK = 4'd9,
        BR_URET   = 4'd10,
        BR_SRET   = 4'd11,
        BR_MRET   = 4'd12,
        BR_NONE   = 4'd15
    } br_op_e;

    // Same as funct3[1:0]
    typedef enum logic [1:0] {
        CSR_RW = 2'd1,
        CSR_RS = 2'd2,
        CSR_RC = 2'd3
    } csr_op_e;

endpackage

/* tb/decode_asserts.sv */
// Bound into decode_top; all checks are disabled while rst_n is low
`timescale 1ns/100ps

module decode_asserts import isa_pkg::*, uop_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       in_valid,
    input logic       in_ready,
    input logic       out_valid,
    input logic       out_ready,
    input logic       sched_valid,
    input xlen_t      out_pc,
    input wid_t       out_wid,
    input ex_type_e   out_ex_type,
    input op_code_t   out_op,
    input alu_xtype_e out_xtype,
    input logic       out_use_imm,
    input logic       out_use_pc,
    input xlen_t      out_imm,
    input logic       out_wb,
    input reg_addr_t  out_rd,
    input reg_addr_t  out_rs1,
    input reg_addr_t  out_rs2,
    input logic [1:0] out_used_rs
);

    property hold_while_stalled;
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable({out_pc, out_wid, out_ex_type,
            out_op, out_xtype, out_use_imm, out_use_pc, out_imm, out_wb, out_rd, out_rs1,
            out_rs2, out_used_rs}));
    endproperty

    property notice_on_transfer;
        @(posedge clk) disable iff (!rst_n)
        sched_valid == (in_valid && in_ready);
    endproperty

    // x0 is never a write-back target
    property wb_needs_rd;
        @(posedge clk) disable iff (!rst_n)
        (out_valid && out_wb) |-> (out_rd != '0);
    endproperty

    assert property (hold_while_stalled) else $error("Outputs changed under back-pressure");
    assert property (notice_on_transfer) else $error("sched_valid does not match a transfer");
    assert property (wb_needs_rd) else $error("Write-back flagged with rd of x0");

endmodule

/* tb/decode_checker.sv */
// Expects one-cycle latency and in-order output; expected micro-ops follow the RV32I rules
`timescale 1ns/100ps
`include "decode_consts.svh"

module decode_checker import isa_pkg::*, uop_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic       in_ready,
    input  instr_t     in_instr,
    input  xlen_t      in_pc,
    input  wid_t       in_wid,
    input  logic       out_valid,
    input  logic       out_ready,
    input  xlen_t      out_pc,
    input  wid_t       out_wid,
    input  ex_type_e   out_ex_type,
    input  op_code_t   out_op,
    input  alu_xtype_e out_xtype,
    input  logic       out_use_imm,
    input  logic       out_use_pc,
    input  xlen_t      out_imm,
    input  logic       out_wb,
    input  reg_addr_t  out_rd,
    input  reg_addr_t  out_rs1,
    input  reg_addr_t  out_rs2,
    input  logic [1:0] out_used_rs,
    input  logic       sched_valid,
    input  logic       sched_unlock,
    input  wid_t       sched_wid,
    output int         in_count,
    output int         out_count,
    output int         err_count
);

    typedef struct packed {
        xlen_t      pc;
        wid_t       wid;
        ex_type_e   ex_type;
        op_code_t   op;
        alu_xtype_e xtype;
        logic       use_imm;
        logic       use_pc;
        xlen_t      imm;
        logic       wb;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic [1:0] used_rs;
        logic       unlock;   // Scheduler notice, not part of the output register
    } uop_t;

    uop_t   exp_q[$];
    instr_t instr_q[$];

    function automatic uop_t decode_ref(input instr_t ins, input xlen_t pc, input wid_t wid);
        uop_t       u;
        logic [2:0] f3;
        logic       use_rd;
        xlen_t      i_sext;
        u        = '0;
        f3       = ins[14:12];
        use_rd   = 1'b0;
        i_sext   = {{20{ins[31]}}, ins[31:20]};
        u.pc     = pc;
        u.wid    = wid;
        u.rd     = ins[11:7];
        u.rs1    = ins[19:15];
        u.rs2    = ins[24:20];
        u.unlock = 1'b1;
        case (ins[6:0])
            7'h13, 7'h33: begin
                u.ex_type = EX_ALU;
                case (f3)
                    3'd0: u.op = (ins[5] && ins[30]) ? 4'd1 : 4'd0;
                    3'd1: u.op = 4'd2;
                    3'd2: u.op = 4'd3;
                    3'd3: u.op = 4'd4;
                    3'd4: u.op = 4'd5;
                    3'd5: u.op = ins[30] ? 4'd7 : 4'd6;
                    3'd6: u.op = 4'd8;
                    default: u.op = 4'd9;
                endcase
                u.use_imm = !ins[5];
                if (!ins[5]) begin
                    u.imm = (f3[1:0] == 2'b01) ? {27'b0, ins[24:20]} : i_sext; // shamt only
                end
                use_rd    = 1'b1;
                u.used_rs = ins[5] ? 2'b11 : 2'b01;
            end
            7'h37, 7'h17: begin
                u.ex_type = EX_ALU;
                u.op      = ins[5] ? 4'd10 : 4'd11;
                u.use_imm = 1'b1;
                u.use_pc  = !ins[5];
                u.imm     = {ins[31:12], 12'b0};
                use_rd    = 1'b1;
            end
            7'h6F: begin
                u.ex_type = EX_ALU;
                u.xtype   = ALU_BRANCH;
                u.op      = 4'd6;
                u.use_imm = 1'b1;
                u.use_pc  = 1'b1;
                u.imm     = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                use_rd    = 1'b1;
                u.unlock  = 1'b0;
            end
            7'h67: begin
                u.ex_type = EX_ALU;
                u.xtype   = ALU_BRANCH;
                u.op      = 4'd7;
                u.use_imm = 1'b1;
                u.imm     = i_sext;
                use_rd    = 1'b1;
                u.used_rs = 2'b01;
                u.unlock  = 1'b0;
            end
            7'h63: begin
                u.ex_type = EX_ALU;
                u.xtype   = ALU_BRANCH;
                case (f3)
                    3'd0: u.op = 4'd0;
                    3'd1: u.op = 4'd1;
                    3'd4: u.op = 4'd2;
                    3'd5: u.op = 4'd3;
                    3'd6: u.op = 4'd4;
                    3'd7: u.op = 4'd5;
                    default: u.op = 4'd15;
                endcase
                u.use_imm = 1'b1;
                u.use_pc  = 1'b1;
                u.imm     = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                u.used_rs = 2'b11;
                u.unlock  = 1'b0;
            end
            7'h0F: u.ex_type = EX_LSU;
            7'h03, 7'h23: begin
                u.ex_type = EX_LSU;
                u.op      = {ins[5], f3};
                u.use_imm = 1'b1;
                u.imm     = ins[5] ? {{20{ins[31]}}, ins[31:25], ins[11:7]} : i_sext;
                use_rd    = !ins[5];
                u.used_rs = ins[5] ? 2'b11 : 2'b01;
            end
            7'h73: begin
                use_rd = 1'b1;
                if (f3[1:0] != 2'b00) begin
                    u.ex_type = EX_SFU;
                    u.op      = {2'b00, f3[1:0]};
                    u.use_imm = f3[2];
                    u.imm     = f3[2] ? {27'b0, ins[19:15]} : {20'b0, ins[31:20]};
                    u.used_rs = f3[2] ? 2'b00 : 2'b01;
                    u.unlock  = (ins[31:20] > `FCSR_ADDR);
                end else begin
                    u.ex_type = EX_ALU;
                    u.xtype   = ALU_BRANCH;
                    case (ins[31:20])
                        12'h000: u.op = 4'd8;
                        12'h001: u.op = 4'd9;
                        12'h002: u.op = 4'd10;
                        12'h102: u.op = 4'd11;
                        12'h302: u.op = 4'd12;
                        default: u.op = 4'd15;
                    endcase
                    u.use_imm = 1'b1;
                    u.use_pc  = 1'b1;
                    u.imm     = (ins[31:20] == 12'h001) ? 32'd0 : `RET_IMM;
                    u.unlock  = 1'b0;
                end
            end
            default: ;
        endcase
        u.wb = use_rd && (u.rd != 5'd0);
        return u;
    endfunction

    function automatic string show(input uop_t u);
        return {$sformatf("ex %0d op %0d xt %0d imm %h ui %b up %b wb %b ",
                          u.ex_type, u.op, u.xtype, u.imm, u.use_imm, u.use_pc, u.wb),
                $sformatf("rd %0d rs %0d,%0d use %b pc %h w %0d",
                          u.rd, u.rs1, u.rs2, u.used_rs, u.pc, u.wid)};
    endfunction

    always @(posedge clk or negedge rst_n) begin : compare_proc
        uop_t   exp;
        uop_t   got;
        instr_t ins;
        logic   fire;
        if (!rst_n) begin
            in_count  = 0;
            out_count = 0;
            err_count = 0;
            exp_q.delete();
            instr_q.delete();
        end else begin
            fire = in_valid && in_ready;
            // Output register is full exactly while one micro-op is pending
            if (out_valid !== (exp_q.size() != 0) ||
                in_ready !== (exp_q.size() == 0 || out_ready)) begin
                $display("FAILED at %0t: out_valid %b in_ready %b with %0d micro-ops pending",
                         $time, out_valid, in_ready, exp_q.size());
                err_count++;
            end
            if (out_valid && out_ready) begin
                got = {out_pc, out_wid, out_ex_type, out_op, out_xtype, out_use_imm, out_use_pc,
                       out_imm, out_wb, out_rd, out_rs1, out_rs2, out_used_rs, 1'b0};
                if (exp_q.size() == 0) begin
                    $display("Output transfer at %0t with no instruction pending", $time);
                    err_count++;
                end else begin
                    exp        = exp_q.pop_front();
                    ins        = instr_q.pop_front();
                    got.unlock = exp.unlock;
                    if (got !== exp) begin
                        $display("FAILED at %0t: instr %h gave [%s] instead of [%s]",
                                 $time, ins, show(got), show(exp));
                        err_count++;
                    end
                end
                out_count++;
            end
            if (sched_valid !== fire) begin
                $display("FAILED at %0t: sched_valid %b in a cycle with transfer %b",
                         $time, sched_valid, fire);
                err_count++;
            end
            if (fire) begin
                exp = decode_ref(in_instr, in_pc, in_wid);
                if (sched_wid !== in_wid || sched_unlock !== exp.unlock) begin
                    $display("FAILED at %0t: instr %h notice wid %0d unlock %b, want %0d %b",
                             $time, in_instr, sched_wid, sched_unlock, in_wid, exp.unlock);
                    err_count++;
                end
                exp_q.push_back(exp);
                instr_q.push_back(in_instr);
                in_count++;
            end
        end
    end

endmodule

/* tb/tb_decode_top.sv */
// Needs hdl/ on the include path; random stimulus from one fixed seed, driven on the falling edge
`timescale 1ns/100ps

module tb_decode_top import isa_pkg::*, uop_pkg::*; ();

    localparam int CLK_PERIOD     = 100;
    localparam int N_ALU          = 300;
    localparam int N_CTRL         = 150;
    localparam int N_MEM          = 150;
    localparam int N_SYS          = 150;
    localparam int N_FLOW         = 500;
    localparam int N_TOTAL        = N_ALU + N_CTRL + N_MEM + N_SYS + N_FLOW;
    localparam int TIMEOUT_CYCLES = N_TOTAL * 4 + 200;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    instr_t     in_instr;
    xlen_t      in_pc;
    wid_t       in_wid;
    logic       out_valid;
    logic       out_ready;
    xlen_t      out_pc;
    wid_t       out_wid;
    ex_type_e   out_ex_type;
    op_code_t   out_op;
    alu_xtype_e out_xtype;
    logic       out_use_imm;
    logic       out_use_pc;
    xlen_t      out_imm;
    logic       out_wb;
    reg_addr_t  out_rd;
    reg_addr_t  out_rs1;
    reg_addr_t  out_rs2;
    logic [1:0] out_used_rs;
    logic       sched_valid;
    logic       sched_unlock;
    wid_t       sched_wid;
    int         in_count;
    int         out_count;
    int         err_count;
    int         stall_pct = 0;

    decode_top decode_top_inst (.*);

    decode_checker decode_checker_inst (.*);

    bind decode_top decode_asserts decode_asserts_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Random back-pressure
    always @(negedge clk) begin
        out_ready = ($urandom_range(99) >= stall_pct);
    end

    // Kind 0 ALU/upper, 1 control flow, 2 memory, 3 system, 4 unknown opcode
    function automatic instr_t rand_instr(input int kind);
        instr_t     ins;
        logic [2:0] pick;
        ins  = $urandom;
        pick = $urandom_range(5);
        case (kind)
            0: begin
                case ($urandom_range(3))
                    0: ins[6:0] = OPC_OP;
                    1: ins[6:0] = OPC_OP_IMM;
                    2: ins[6:0] = OPC_LUI;
                    default: ins[6:0] = OPC_AUIPC;
                endcase
                if ($urandom_range(7) == 0) begin
                    ins[11:7] = 5'd0;
                end
            end
            1: begin
                case ($urandom_range(2))
                    0: ins[6:0] = OPC_JAL;
                    1: ins[14:0] = {3'b000, ins[11:7], OPC_JALR};
                    default: ins[14:0] = {(pick < 2) ? pick : pick + 3'd2, ins[11:7], OPC_BRANCH};
                endcase
            end
            2: begin
                case ($urandom_range(2))
                    0: ins[14:0] = {(pick < 3) ? pick : pick + 3'd1, ins[11:7], OPC_LOAD};
                    1: ins[14:0] = {3'(pick % 3), ins[11:7], OPC_STORE};
                    default: ins[6:0] = OPC_FENCE;
                endcase
            end
            3: begin
                if ($urandom_range(1) == 0) begin
                    ins[14:0] = {(pick < 3) ? pick + 3'd1 : pick + 3'd2, ins[11:7], OPC_SYSTEM};
                    if ($urandom_range(1) == 0) begin
                        ins[31:20] = $urandom_range(7); // Near the FPU CSRs
                    end
                end else begin
                    case (pick)
                        0: ins[31:20] = 12'h000;
                        1: ins[31:20] = 12'h001;
                        2: ins[31:20] = 12'h002;
                        3: ins[31:20] = 12'h102;
                        default: ins[31:20] = 12'h302;
                    endcase
                    ins[19:0] = {13'b0, OPC_SYSTEM};
                end
            end
            default: begin
                case ($urandom_range(3))
                    0: ins[6:0] = 7'h07;
                    1: ins[6:0] = 7'h0B;
                    2: ins[6:0] = 7'h2F;
                    default: ins[6:0] = 7'h5B;
                endcase
            end
        endcase
        return ins;
    endfunction

    task automatic send_instr(input instr_t ins);
        @(negedge clk);
        in_valid = 1'b1;
        in_instr = ins;
        in_pc    = $urandom & 32'hFFFF_FFFC;
        in_wid   = $urandom_range(3);
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic run_test(input string name, input int kind, input int n, input int stall,
                            input int gap);
        int err_before;
        int k;
        err_before = err_count;
        stall_pct  = stall;
        for (int i = 0; i < n; i++) begin
            if ($urandom_range(99) < gap) begin
                @(negedge clk);
                in_valid = 1'b0;
                repeat ($urandom_range(2)) @(negedge clk);
            end
            k = (kind == 4) ? $urandom_range(4) : kind; // Mixed traffic
            send_instr(rand_instr(k));
        end
        @(negedge clk);
        in_valid  = 1'b0;
        stall_pct = 0;
        while (out_count != in_count) begin
            @(negedge clk);
        end
        $display("test %s: %0d vectors, %0d errors", name, n, err_count - err_before);
    endtask

    initial begin
        void'($urandom(32'h74bab078));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        in_pc     = '0;
        in_wid    = '0;
        out_ready = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        run_test("alu_upper", 0, N_ALU, 0, 0);
        run_test("control", 1, N_CTRL, 0, 0);
        run_test("memory", 2, N_MEM, 0, 0);
        run_test("system", 3, N_SYS, 0, 0);
        run_test("flow", 4, N_FLOW, 30, 30);
        $display("Summary: %0d sent, %0d received, %0d errors", in_count, out_count, err_count);
        if (err_count == 0 && out_count == N_TOTAL) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Run timed out after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
